// File: params_pkg.sv
package params_pkg;

  // ============================================================
  // Widths
  // ============================================================

  localparam int DATA_WIDTH     = 32; // Register and datapath width.
  localparam int ADDR_WIDTH     = 32; // PC width.
  localparam int REGISTER_WIDTH = 5;
  localparam int OPCODE_WIDTH   = 7;

  // ============================================================
  // Instruction encoding
  // ============================================================

  typedef enum logic [OPCODE_WIDTH-1:0] {
    R         = 7'b0110011,
    IMMEDIATE = 7'b0010011,
    LOAD      = 7'b0000011,
    STORE     = 7'b0100011,
    BRANCH    = 7'b1100011,
    JAL       = 7'b1101111,
    AUIPC     = 7'b0010111
  } opcode_e;

  // R-format layout. Other formats read raw bit positions.
  typedef struct packed {
    logic [6:0]                funct7;
    logic [REGISTER_WIDTH-1:0] rs2;
    logic [REGISTER_WIDTH-1:0] rs1;
    logic [2:0]                funct3;
    logic [REGISTER_WIDTH-1:0] rd;
    opcode_e                   opcode;
  } instruction_t;

  // ============================================================
  // Pipeline bundles
  // ============================================================

  typedef struct packed {
    logic                      valid;
    logic [ADDR_WIDTH-1:0]     pc;
    logic [DATA_WIDTH-1:0]     rs1_data;
    logic [DATA_WIDTH-1:0]     rs2_data;
    logic [DATA_WIDTH-1:0]     imm;      // Sign-extended immediate.
    logic [REGISTER_WIDTH-1:0] rd;
    instruction_t              instr;
  } alu_req_t;

  typedef struct packed {
    logic                      valid;
    logic [REGISTER_WIDTH-1:0] rd;
    logic [DATA_WIDTH-1:0]     rs1_data;
    logic [DATA_WIDTH-1:0]     rs2_data;
  } mul_req_t;

  typedef struct packed {
    logic                      valid;
    logic [REGISTER_WIDTH-1:0] rd;
    logic [DATA_WIDTH-1:0]     data;
  } wb_t;

endpackage : params_pkg

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  instr_valid_i,
  input  logic                                  flush_i,
  input  logic                                  mem_stall_i,
  input  params_pkg::instruction_t              instr_i,
  input  logic [params_pkg::ADDR_WIDTH-1:0]     pc_i,
  input  logic [params_pkg::DATA_WIDTH-1:0]     rs1_data_i,
  input  logic [params_pkg::DATA_WIDTH-1:0]     rs2_data_i,
  input  logic                                  ex2_valid_i,
  input  logic                                  ex3_valid_i,
  input  logic                                  ex4_valid_i,
  input  logic [params_pkg::REGISTER_WIDTH-1:0] ex2_wr_reg_i,
  input  logic [params_pkg::REGISTER_WIDTH-1:0] ex3_wr_reg_i,
  input  logic [params_pkg::REGISTER_WIDTH-1:0] ex4_wr_reg_i,
  input  params_pkg::wb_t                       wb_i,
  output logic                                  stall_o,
  output logic [params_pkg::REGISTER_WIDTH-1:0] rs1_o,
  output logic [params_pkg::REGISTER_WIDTH-1:0] rs2_o,
  output params_pkg::alu_req_t                  alu_req_o,
  output params_pkg::mul_req_t                  mul_req_o
);

  localparam int RW = params_pkg::REGISTER_WIDTH;

  logic [params_pkg::DATA_WIDTH-1:0] imm;
  logic [params_pkg::DATA_WIDTH-1:0] rs1_val;
  logic [params_pkg::DATA_WIDTH-1:0] rs2_val;
  logic                              is_mul;
  logic                              writes_alu;
  logic                              reads_operands;
  logic                              raw_hazard;
  logic                              waw_hazard;
  logic                              wb_collision;
  logic                              issue;
  logic [4:0]                        stage_valid;
  logic [4:0][RW-1:0]                stage_rd;
  params_pkg::alu_req_t              alu_req_d;
  params_pkg::mul_req_t              mul_req_d;

  function automatic logic reg_hit(input logic          valid,
                                   input logic [RW-1:0] stage_reg,
                                   input logic [RW-1:0] src);
    return valid && (src != '0) && (src == stage_reg);
  endfunction

  // ============================================================
  // Decode
  // ============================================================

  assign is_mul = (instr_i.opcode == params_pkg::R) && (instr_i.funct3 == 3'b000) &&
                  (instr_i.funct7 == 7'b0000001);
  assign writes_alu = ((instr_i.opcode == params_pkg::R) && !is_mul) ||
                      (instr_i.opcode == params_pkg::IMMEDIATE) ||
                      (instr_i.opcode == params_pkg::JAL) ||
                      (instr_i.opcode == params_pkg::AUIPC);
  assign reads_operands = (instr_i.opcode != params_pkg::JAL) &&
                          (instr_i.opcode != params_pkg::AUIPC);

  always_comb begin : immediate
    case (instr_i.opcode)
      params_pkg::LOAD,
      params_pkg::IMMEDIATE : imm = {{20{instr_i[31]}}, instr_i[31:20]};
      params_pkg::STORE     : imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      params_pkg::BRANCH    : imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                     instr_i[11:8], 1'b0};
      params_pkg::JAL       : imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                                     instr_i[30:21], 1'b0};
      params_pkg::AUIPC     : imm = {instr_i[31:12], 12'b0};
      default               : imm = '0;
    endcase
  end

  assign rs1_o = instr_i.rs1;
  assign rs2_o = instr_i.rs2;

  // Writeback value not yet in the register file.
  assign rs1_val = reg_hit(wb_i.valid, wb_i.rd, instr_i.rs1) ? wb_i.data : rs1_data_i;
  assign rs2_val = reg_hit(wb_i.valid, wb_i.rd, instr_i.rs2) ? wb_i.data : rs2_data_i;

  // ============================================================
  // Hazards
  // ============================================================

  // Index 0 is the ALU stage, 1 to 4 are ex1 to ex4.
  assign stage_valid = {ex4_valid_i, ex3_valid_i, ex2_valid_i, mul_req_o.valid, alu_req_o.valid};
  assign stage_rd    = {ex4_wr_reg_i, ex3_wr_reg_i, ex2_wr_reg_i, mul_req_o.rd, alu_req_o.rd};

  always_comb begin : hazards
    raw_hazard = 1'b0;
    waw_hazard = 1'b0;
    for (int i = 0; i < 5; i++) begin
      raw_hazard |= reg_hit(stage_valid[i], stage_rd[i], instr_i.rs1) |
                    reg_hit(stage_valid[i], stage_rd[i], instr_i.rs2);
      if (i > 0) begin
        waw_hazard |= reg_hit(stage_valid[i], stage_rd[i], instr_i.rd);
      end
    end
    raw_hazard &= reads_operands;
  end

  assign wb_collision = writes_alu & ex3_valid_i; // Would meet ex4 in writeback.

  assign stall_o = instr_valid_i &
                   (mem_stall_i | (~flush_i & (raw_hazard | waw_hazard | wb_collision)));
  assign issue   = instr_valid_i & ~flush_i & ~stall_o;

  // ============================================================
  // Issue registers
  // ============================================================

  assign alu_req_d = '{valid: issue & ~is_mul, pc: pc_i, rs1_data: rs1_val,
                       rs2_data: rs2_val, imm: imm, rd: instr_i.rd, instr: instr_i};
  assign mul_req_d = '{valid: issue & is_mul, rd: instr_i.rd,
                       rs1_data: rs1_val, rs2_data: rs2_val};

  always_ff @(posedge clk_i) begin : issue_regs
    alu_req_o <= alu_req_d;
    mul_req_o <= mul_req_d; // Ex1 stage.
    if (!rst_i) begin
      alu_req_o.valid <= 1'b0;
      mul_req_o.valid <= 1'b0;
    end
  end

endmodule : decode_stage

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic [params_pkg::REGISTER_WIDTH-1:0] rs1_i,
  input  logic [params_pkg::REGISTER_WIDTH-1:0] rs2_i,
  input  params_pkg::wb_t                       wb_i,
  output logic [params_pkg::DATA_WIDTH-1:0]     rs1_data_o,
  output logic [params_pkg::DATA_WIDTH-1:0]     rs2_data_o
);

  localparam int NUM_REGS = 2 ** params_pkg::REGISTER_WIDTH;

  logic [params_pkg::DATA_WIDTH-1:0] regs [NUM_REGS];

  // ============================================================
  // Write port
  // ============================================================

  always_ff @(posedge clk_i) begin : write_port
    if (!rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.valid && (wb_i.rd != '0)) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // ============================================================
  // Read ports
  // ============================================================

  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i]; // x0 reads zero.
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule : reg_file

// File: alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
  input  params_pkg::alu_req_t alu_req_i,
  output params_pkg::wb_t      result_o
);

  localparam int DW = params_pkg::DATA_WIDTH;

  logic [DW-1:0] op_a;
  logic [DW-1:0] op_b;
  logic [DW-1:0] sra_val;
  logic [DW-1:0] alu_out;
  logic [DW-1:0] result;
  logic [4:0]    shamt;
  logic          is_r;
  logic          alt;
  logic          writes_reg;

  assign is_r    = alu_req_i.instr.opcode == params_pkg::R;
  assign alt     = alu_req_i.instr.funct7[5]; // SUB and SRA select.
  assign op_a    = alu_req_i.rs1_data;
  assign op_b    = is_r ? alu_req_i.rs2_data : alu_req_i.imm;
  assign shamt   = op_b[4:0];
  assign sra_val = $signed(op_a) >>> shamt;

  // ============================================================
  // Operations
  // ============================================================

  always_comb begin : compute
    case (alu_req_i.instr.funct3)
      3'b000 : begin
        if (is_r && alt) begin
          alu_out = op_a - op_b;
        end else begin
          alu_out = op_a + op_b;
        end
      end
      3'b001 : alu_out = op_a << shamt;
      3'b010 : alu_out = {{(DW-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      3'b011 : alu_out = {{(DW-1){1'b0}}, op_a < op_b};
      3'b100 : alu_out = op_a ^ op_b;
      3'b101 : begin
        if (alt) begin
          alu_out = sra_val;
        end else begin
          alu_out = op_a >> shamt;
        end
      end
      3'b110 : alu_out = op_a | op_b;
      default: alu_out = op_a & op_b;
    endcase
  end

  always_comb begin : select
    case (alu_req_i.instr.opcode)
      params_pkg::JAL   : result = alu_req_i.pc + 32'd4; // Link address.
      params_pkg::AUIPC : result = alu_req_i.pc + alu_req_i.imm;
      default           : result = alu_out;
    endcase
  end

  // LOAD, STORE and BRANCH leave no register result here.
  assign writes_reg = is_r ||
                      (alu_req_i.instr.opcode == params_pkg::IMMEDIATE) ||
                      (alu_req_i.instr.opcode == params_pkg::JAL) ||
                      (alu_req_i.instr.opcode == params_pkg::AUIPC);

  assign result_o = '{valid: alu_req_i.valid & writes_reg, rd: alu_req_i.rd, data: result};

endmodule : alu_unit

// File: mul_pipe.sv
`timescale 1ns/1ps

module mul_pipe (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  params_pkg::mul_req_t                  mul_req_i,
  output logic                                  ex2_valid_o,
  output logic                                  ex3_valid_o,
  output logic                                  ex4_valid_o,
  output logic [params_pkg::REGISTER_WIDTH-1:0] ex2_wr_reg_o,
  output logic [params_pkg::REGISTER_WIDTH-1:0] ex3_wr_reg_o,
  output logic [params_pkg::REGISTER_WIDTH-1:0] ex4_wr_reg_o,
  output params_pkg::wb_t                       result_o
);

  logic [params_pkg::DATA_WIDTH-1:0] product;
  params_pkg::wb_t                   ex2_q;
  params_pkg::wb_t                   ex3_q;
  params_pkg::wb_t                   ex4_q;

  assign product = mul_req_i.rs1_data * mul_req_i.rs2_data; // Low half only.

  // ============================================================
  // Stages ex2 to ex4
  // ============================================================

  always_ff @(posedge clk_i) begin : stages
    ex2_q <= '{valid: mul_req_i.valid, rd: mul_req_i.rd, data: product};
    ex3_q <= ex2_q;
    ex4_q <= ex3_q;
    if (!rst_i) begin
      ex2_q.valid <= 1'b0;
      ex3_q.valid <= 1'b0;
      ex4_q.valid <= 1'b0;
    end
  end

  assign ex2_valid_o  = ex2_q.valid;
  assign ex3_valid_o  = ex3_q.valid;
  assign ex4_valid_o  = ex4_q.valid;
  assign ex2_wr_reg_o = ex2_q.rd;
  assign ex3_wr_reg_o = ex3_q.rd;
  assign ex4_wr_reg_o = ex4_q.rd;

  assign result_o = ex4_q; // Goes to writeback next edge.

endmodule : mul_pipe

// File: writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit (
  input  logic            clk_i,
  input  logic            rst_i,
  input  params_pkg::wb_t alu_result_i,
  input  params_pkg::wb_t mul_result_i,
  output params_pkg::wb_t wb_o
);

  params_pkg::wb_t wb_d;

  // ============================================================
  // Result select
  // ============================================================

  // Decode never lets both be valid in the same cycle.
  always_comb begin : select
    if (alu_result_i.valid) begin
      wb_d = alu_result_i;
    end else begin
      wb_d = mul_result_i;
    end
    if (wb_d.rd == '0) begin
      wb_d.valid = 1'b0; // Writes to x0 are dropped.
    end
  end

  // ============================================================
  // Writeback stage
  // ============================================================

  always_ff @(posedge clk_i) begin : wb_stage
    wb_o <= wb_d;
    if (!rst_i) begin
      wb_o.valid <= 1'b0;
    end
  end

endmodule : writeback_unit

// File: core_top.sv
`timescale 1ns/1ps

module core_top (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              instr_valid_i,
  input  logic                              flush_i,
  input  logic                              mem_stall_i,
  input  params_pkg::instruction_t          instr_i,
  input  logic [params_pkg::ADDR_WIDTH-1:0] pc_i,
  output logic                              stall_o,
  output params_pkg::wb_t                   retire_o
);

  logic [params_pkg::REGISTER_WIDTH-1:0] rs1;
  logic [params_pkg::REGISTER_WIDTH-1:0] rs2;
  logic [params_pkg::DATA_WIDTH-1:0]     rs1_data;
  logic [params_pkg::DATA_WIDTH-1:0]     rs2_data;
  logic                                  ex2_valid;
  logic                                  ex3_valid;
  logic                                  ex4_valid;
  logic [params_pkg::REGISTER_WIDTH-1:0] ex2_wr_reg;
  logic [params_pkg::REGISTER_WIDTH-1:0] ex3_wr_reg;
  logic [params_pkg::REGISTER_WIDTH-1:0] ex4_wr_reg;
  params_pkg::alu_req_t                  alu_req;
  params_pkg::mul_req_t                  mul_req;
  params_pkg::wb_t                       alu_result;
  params_pkg::wb_t                       mul_result;

  // ============================================================
  // Input side
  // ============================================================

  decode_stage i_decode_stage (
    .clk_i, .rst_i, .instr_valid_i, .flush_i, .mem_stall_i, .instr_i, .pc_i,
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .ex2_valid_i(ex2_valid), .ex3_valid_i(ex3_valid), .ex4_valid_i(ex4_valid),
    .ex2_wr_reg_i(ex2_wr_reg), .ex3_wr_reg_i(ex3_wr_reg), .ex4_wr_reg_i(ex4_wr_reg),
    .wb_i(retire_o), .stall_o, .rs1_o(rs1), .rs2_o(rs2),
    .alu_req_o(alu_req), .mul_req_o(mul_req)
  );

  reg_file i_reg_file (
    .clk_i, .rst_i, .rs1_i(rs1), .rs2_i(rs2), .wb_i(retire_o),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  // ============================================================
  // Processing and writeback
  // ============================================================

  alu_unit i_alu_unit (.alu_req_i(alu_req), .result_o(alu_result));

  mul_pipe i_mul_pipe (
    .clk_i, .rst_i, .mul_req_i(mul_req),
    .ex2_valid_o(ex2_valid), .ex3_valid_o(ex3_valid), .ex4_valid_o(ex4_valid),
    .ex2_wr_reg_o(ex2_wr_reg), .ex3_wr_reg_o(ex3_wr_reg), .ex4_wr_reg_o(ex4_wr_reg),
    .result_o(mul_result)
  );

  writeback_unit i_writeback_unit (
    .clk_i, .rst_i, .alu_result_i(alu_result), .mul_result_i(mul_result), .wb_o(retire_o)
  );

endmodule : core_top

// File: tb_core_top.sv
`timescale 1ns/1ps

module tb_core_top;

  logic                     clk_i;
  logic                     rst_i;
  logic                     instr_valid_i;
  logic                     flush_i;
  logic                     mem_stall_i;
  params_pkg::instruction_t instr_i;
  logic [31:0]              pc_i;
  logic                     stall_o;
  params_pkg::wb_t          retire_o;

  logic [31:0]     shadow [32];   // Architectural register model.
  params_pkg::wb_t expected_q [$];
  logic [31:0]     pc_next;
  int              sent_count;
  int              mismatch_count;
  int              error_count;

  core_top i_core_top (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ============================================================
  // Encoders and reference model
  // ============================================================

  function automatic params_pkg::instruction_t r_type(input logic [6:0] f7,
      input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return params_pkg::instruction_t'({f7, rs2, rs1, f3, rd, params_pkg::R});
  endfunction

  function automatic params_pkg::instruction_t i_type(input params_pkg::opcode_e op,
      input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    return params_pkg::instruction_t'({imm, rs1, f3, rd, op});
  endfunction

  function automatic params_pkg::instruction_t u_type(input params_pkg::opcode_e op,
      input logic [4:0] rd, input logic [19:0] imm);
    return params_pkg::instruction_t'({imm, rd, op});
  endfunction

  function automatic logic writes_reg(input params_pkg::instruction_t ins);
    return (ins.rd != 5'd0) && (ins.opcode inside {params_pkg::R, params_pkg::IMMEDIATE,
                                                   params_pkg::JAL, params_pkg::AUIPC});
  endfunction

  function automatic logic [31:0] model_result(input params_pkg::instruction_t ins,
                                               input logic [31:0] pc);
    logic [31:0]        word;
    logic [31:0]        a;
    logic [31:0]        b;
    logic signed [31:0] sa;
    logic [4:0]         sh;
    logic               is_r;
    word = ins;
    is_r = ins.opcode == params_pkg::R;
    a    = shadow[ins.rs1];
    b    = is_r ? shadow[ins.rs2] : {{20{word[31]}}, word[31:20]};
    sa   = a;
    sh   = b[4:0];
    if (ins.opcode == params_pkg::JAL) return pc + 32'd4;
    if (ins.opcode == params_pkg::AUIPC) return pc + {word[31:12], 12'b0};
    if (is_r && ins.funct7 == 7'b0000001) return a * b; // Low word of the product.
    case (ins.funct3)
      3'd0: return (is_r && ins.funct7[5]) ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (ins.funct7[5]) return sa >>> sh; // Arithmetic shift.
        return a >> sh;
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // ============================================================
  // Checks and monitor
  // ============================================================

  task automatic check_wb(input string name, input params_pkg::wb_t actual,
                          input params_pkg::wb_t expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %0b/x%0d/%h, expected %0b/x%0d/%h",
               $time, name, actual.valid, actual.rd, actual.data,
               expected.valid, expected.rd, expected.data);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %b, expected %b", $time, name, actual, expected);
    end
  endtask

  // Writes to one register retire in order, so match the oldest entry for that rd.
  always @(negedge clk_i) begin : retire_monitor
    int idx;
    if (rst_i && retire_o.valid) begin
      idx = -1;
      for (int i = expected_q.size() - 1; i >= 0; i--) begin
        if (expected_q[i].rd == retire_o.rd) idx = i;
      end
      if (idx < 0) begin
        error_count++;
        $display("Error at %0t: unexpected retire to x%0d", $time, retire_o.rd);
      end else begin
        check_wb("retire_o", retire_o, expected_q[idx]);
        expected_q.delete(idx);
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 200 * sent_count + 500) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Error: timeout after %0d cycles with %0d instructions sent", cycles, sent_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ============================================================
  // Stimulus helpers
  // ============================================================

  task automatic send_instr(input params_pkg::instruction_t ins, input logic flush);
    logic [31:0] value;
    logic        accepted;
    value    = model_result(ins, pc_next);
    accepted = 1'b0;
    @(negedge clk_i);
    instr_valid_i = 1'b1;
    instr_i       = ins;
    pc_i          = pc_next;
    flush_i       = flush;
    sent_count++;
    while (!accepted) begin
      #1;
      accepted = !stall_o; // Stable until the rising edge.
      @(posedge clk_i);
      if (!accepted) @(negedge clk_i);
    end
    pc_next = pc_next + 32'd4;
    if (!flush && writes_reg(ins)) begin
      shadow[ins.rd] = value;
      expected_q.push_back('{valid: 1'b1, rd: ins.rd, data: value});
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      instr_valid_i = 1'b0;
      flush_i       = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    idle(1);
    while (expected_q.size() != 0 && n < 50) begin
      @(negedge clk_i);
      #2;
      n++;
    end
  endtask

  task automatic load_reg(input logic [4:0] rd);
    send_instr(i_type(params_pkg::IMMEDIATE, 3'b000, rd, 5'd0, 12'($urandom)), 1'b0);
    send_instr(i_type(params_pkg::IMMEDIATE, 3'b001, rd, rd, {7'b0, 5'($urandom % 20)}), 1'b0);
    send_instr(i_type(params_pkg::IMMEDIATE, 3'b100, rd, rd, 12'($urandom)), 1'b0);
  endtask

  // ============================================================
  // Directed tests
  // ============================================================

  task automatic test_alu_ops();
    load_reg(5'd1);
    load_reg(5'd2);
    for (int f = 0; f < 8; f++) begin
      send_instr(r_type(7'h00, 5'd2, 5'd1, 3'(f), 5'(3 + f)), 1'b0);
    end
    send_instr(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd11), 1'b0); // SUB.
    send_instr(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd12), 1'b0); // SRA.
    foreach (shadow[f]) begin
      if (f < 8 && f != 1 && f != 5) begin
        send_instr(i_type(params_pkg::IMMEDIATE, 3'(f), 5'(13 + f), 5'd1, 12'($urandom)), 1'b0);
      end
    end
    send_instr(i_type(params_pkg::IMMEDIATE, 3'b001, 5'd21, 5'd1, 12'h00d), 1'b0);
    send_instr(i_type(params_pkg::IMMEDIATE, 3'b101, 5'd22, 5'd1, 12'h013), 1'b0);
    send_instr(i_type(params_pkg::IMMEDIATE, 3'b101, 5'd23, 5'd1, 12'h407), 1'b0);
    send_instr(u_type(params_pkg::JAL, 5'd24, 20'($urandom)), 1'b0);
    send_instr(u_type(params_pkg::AUIPC, 5'd25, 20'($urandom)), 1'b0);
    wait_drain();
  endtask

  task automatic test_mul_stream();
    for (int r = 1; r <= 4; r++) load_reg(5'(r));
    send_instr(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd10), 1'b0);
    send_instr(r_type(7'h01, 5'd4, 5'd3, 3'b000, 5'd11), 1'b0);
    send_instr(r_type(7'h01, 5'd3, 5'd1, 3'b000, 5'd12), 1'b0);
    send_instr(r_type(7'h01, 5'd4, 5'd2, 3'b000, 5'd13), 1'b0);
    send_instr(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd14), 1'b0); // Held while ex3 is busy.
    wait_drain();
  endtask

  task automatic test_dependencies();
    send_instr(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), 1'b0);
    send_instr(r_type(7'h20, 5'd1, 5'd5, 3'b000, 5'd6), 1'b0);  // ALU to ALU.
    send_instr(r_type(7'h01, 5'd5, 5'd6, 3'b000, 5'd7), 1'b0);  // ALU to MUL.
    send_instr(r_type(7'h00, 5'd1, 5'd7, 3'b000, 5'd8), 1'b0);  // MUL to ALU.
    send_instr(r_type(7'h01, 5'd8, 5'd8, 3'b000, 5'd9), 1'b0);
    send_instr(i_type(params_pkg::IMMEDIATE, 3'b000, 5'd9, 5'd9, 12'h003), 1'b0);
    send_instr(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd14), 1'b0);
    send_instr(i_type(params_pkg::IMMEDIATE, 3'b000, 5'd14, 5'd0, 12'h007), 1'b0); // WAW.
    wait_drain();
  endtask

  task automatic test_no_write();
    send_instr(i_type(params_pkg::IMMEDIATE, 3'b000, 5'd20, 5'd1, 12'h055), 1'b1);
    send_instr(i_type(params_pkg::LOAD, 3'b010, 5'd21, 5'd1, 12'h010), 1'b0);
    send_instr(i_type(params_pkg::STORE, 3'b010, 5'd22, 5'd1, 12'h024), 1'b0);
    send_instr(i_type(params_pkg::BRANCH, 3'b000, 5'd23, 5'd1, 12'h042), 1'b0);
    idle(8);
    send_instr(r_type(7'h00, 5'd0, 5'd20, 3'b000, 5'd26), 1'b0);
    wait_drain();
  endtask

  task automatic test_mem_stall();
    params_pkg::instruction_t ins;
    ins = i_type(params_pkg::IMMEDIATE, 3'b000, 5'd27, 5'd1, 12'($urandom));
    @(negedge clk_i);
    mem_stall_i = 1'b1;
    fork
      send_instr(ins, 1'b0);
      begin
        @(negedge clk_i);
        repeat (6) begin
          #1;
          check_bit("stall_o", stall_o, 1'b1);
          check_bit("retire_o.valid", retire_o.valid, 1'b0);
          @(negedge clk_i);
        end
        mem_stall_i = 1'b0; // Held slot goes on the next rising edge.
      end
    join
    wait_drain();
  endtask

  task automatic test_x0();
    send_instr(i_type(params_pkg::IMMEDIATE, 3'b000, 5'd0, 5'd1, 12'h005), 1'b0);
    send_instr(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd0), 1'b0);
    send_instr(u_type(params_pkg::JAL, 5'd0, 20'h00010), 1'b0);
    send_instr(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd28), 1'b0);
    send_instr(r_type(7'h20, 5'd0, 5'd1, 3'b000, 5'd29), 1'b0);
    wait_drain();
  endtask

  initial begin : main
    void'($urandom(58357));
    rst_i          = 1'b0;
    instr_valid_i  = 1'b0;
    flush_i        = 1'b0;
    mem_stall_i    = 1'b0;
    instr_i        = params_pkg::instruction_t'(32'h0000_0013); // NOP.
    pc_i           = '0;
    pc_next        = 32'h0000_1000;
    sent_count     = 0;
    mismatch_count = 0;
    error_count    = 0;
    foreach (shadow[i]) shadow[i] = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b1;
    check_bit("stall_o", stall_o, 1'b0);
    check_bit("retire_o.valid", retire_o.valid, 1'b0);
    test_alu_ops();
    test_mul_stream();
    test_dependencies();
    test_no_write();
    test_mem_stall();
    test_x0();
    idle(10);
    if (expected_q.size() != 0) begin
      error_count++;
      $display("Error: %0d expected results never retired", expected_q.size());
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
    if (mismatch_count == 0 && error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_core_top

// File: all.f
params_pkg.sv
decode_stage.sv
reg_file.sv
alu_unit.sv
mul_pipe.sv
writeback_unit.sv
core_top.sv
tb_core_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)

sim: build
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
